/* sim/flush_cases.txt */
// hex op_index_arg_val: op 1 write (arg = way mask), op 2 read (arg = way, val = expected)
// op 3 starts a flush and ignores the other columns
1_03_1_1
2_03_0_1
1_03_2_1
1_03_2_1
1_03_1_0
2_03_0_0
2_03_1_1
1_3f_3_1
3_00_0_0
2_03_1_0
2_3f_0_0
3_00_0_0
1_10_3_1
1_11_1_1
1_12_2_1
1_13_3_1
1_14_3_1
1_15_3_1
3_00_0_0
2_15_1_0
2_10_0_0

/* all.f */
logic/dcache_pkg.sv
logic/dirty_table.sv
logic/flush_walker.sv
logic/wb_queue.sv
logic/wb_drain.sv
logic/dcache_flush_top.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_top
FILELIST  := all.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
LOG       := sim.log

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_top.sv */
module tb_top
    import dcache_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_cases     = 64;
    localparam int clk_period_ns = 4;

    // op, index, way or mask, value
    logic [19:0]            cases [max_cases];
    logic                   clk;
    logic                   rstn;
    way_mask_t              we;
    set_index_t             w_addr;
    logic                   w_data;
    set_index_t             r_addr;
    logic                   r_way;
    logic                   r_dirty;
    logic                   ibar;
    logic                   flush_busy;
    logic                   flush_done;
    logic                   wb_valid;
    wb_req_t                wb_req;
    logic                   wb_ack = 1'b0;
    logic [count_width-1:0] dirty_count;
    logic                   read_check;
    logic                   read_expect;
    logic                   end_check;
    int                     mismatch_count;
    int                     failure_count;
    int                     num_cases;
    int                     bad_ops;
    logic                   ack_armed;
    int unsigned            ack_wait;
    int unsigned            ack_delay;

    tb_clock #(.period_ns(clk_period_ns)) u_clock (.clk(clk));

    dcache_flush_top u_dut (
        .clk(clk), .rstn(rstn),
        .we(we), .w_addr(w_addr), .w_data(w_data),
        .r_addr(r_addr), .r_way(r_way), .r_dirty(r_dirty),
        .ibar(ibar), .flush_busy(flush_busy), .flush_done(flush_done),
        .wb_valid(wb_valid), .wb_req(wb_req), .wb_ack(wb_ack),
        .dirty_count(dirty_count)
    );

    tb_checker u_checker (
        .clk(clk), .rstn(rstn),
        .we(we), .w_addr(w_addr), .w_data(w_data),
        .r_addr(r_addr), .r_way(r_way), .r_dirty(r_dirty),
        .ibar(ibar), .flush_busy(flush_busy), .flush_done(flush_done),
        .wb_valid(wb_valid), .wb_req(wb_req), .wb_ack(wb_ack),
        .dirty_count(dirty_count),
        .read_check(read_check), .read_expect(read_expect), .end_check(end_check),
        .mismatch_count(mismatch_count), .failure_count(failure_count)
    );

    task automatic write_set(set_index_t index, way_mask_t mask, logic value);
        @(posedge clk);
        we     <= mask;
        w_addr <= index;
        w_data <= value;
        @(posedge clk);
        we     <= '0;
    endtask

    task automatic read_set(set_index_t index, logic way, logic exp_bit);
        @(posedge clk);
        r_addr      <= index;
        r_way       <= way;
        read_expect <= exp_bit;
        read_check  <= 1'b1;
        @(posedge clk);
        read_check  <= 1'b0;
    endtask

    task automatic run_flush();
        @(posedge clk);
        ibar <= 1'b1;
        @(posedge clk);
        ibar <= 1'b0;
        @(negedge clk);
        while (!flush_done) begin
            @(negedge clk);
        end
    endtask

    // memory side acks each request after 0 to 3 extra cycles
    always @(posedge clk) begin
        if (!rstn) begin
            wb_ack    <= 1'b0;
            ack_armed <= 1'b0;
            ack_wait  <= 0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_valid && !ack_armed) begin
            ack_delay = $urandom % 4;
            if (ack_delay == 0) begin
                wb_ack <= 1'b1;
            end else begin
                ack_armed <= 1'b1;
                ack_wait  <= ack_delay - 1;
            end
        end else if (ack_armed) begin
            if (ack_wait == 0) begin
                wb_ack    <= 1'b1;
                ack_armed <= 1'b0;
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end
    end

    initial begin
        void'($urandom(32'h230f));
        rstn        = 1'b0;
        we          = '0;
        w_addr      = '0;
        w_data      = 1'b0;
        r_addr      = '0;
        r_way       = 1'b0;
        ibar        = 1'b0;
        read_check  = 1'b0;
        read_expect = 1'b0;
        end_check   = 1'b0;
        bad_ops     = 0;
        for (int i = 0; i < max_cases; i++) begin
            cases[i] = '0;
        end
        $readmemh("sim/flush_cases.txt", cases);
        num_cases = 0;
        while ((num_cases < max_cases) && (cases[num_cases][19:16] != 4'h0)) begin
            num_cases++;
        end
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < num_cases; i++) begin
            case (cases[i][19:16])
                4'h1: write_set(cases[i][13:8], cases[i][5:4], cases[i][0]);
                4'h2: read_set(cases[i][13:8], cases[i][4], cases[i][0]);
                4'h3: run_flush();
                default: begin
                    $display("ERROR: unknown operation %h in case line %0d", cases[i], i);
                    bad_ops++;
                end
            endcase
        end
        repeat (4) @(posedge clk);
        end_check <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures, %0d bad case lines",
                 mismatch_count, failure_count, bad_ops);
        if ((mismatch_count == 0) && (failure_count == 0) && (bad_ops == 0)) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // worst case per line is a full scan of every set
    initial begin
        #1;
        #((num_cases + 1) * num_sets * 8 * clk_period_ns);
        $display("ERROR: watchdog expired at time %0t, the run did not complete", $time);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* sim/tb_checker.sv */
module tb_checker
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  way_mask_t              we,
    input  set_index_t             w_addr,
    input  logic                   w_data,
    input  set_index_t             r_addr,
    input  logic                   r_way,
    input  logic                   r_dirty,
    input  logic                   ibar,
    input  logic                   flush_busy,
    input  logic                   flush_done,
    input  logic                   wb_valid,
    input  wb_req_t                wb_req,
    input  logic                   wb_ack,
    input  logic [count_width-1:0] dirty_count,
    input  logic                   read_check,
    input  logic                   read_expect,
    input  logic                   end_check,
    output int                     mismatch_count,
    output int                     failure_count
);
    timeunit 1ns;
    timeprecision 100ps;

    // reference copy of the dirty bits
    way_mask_t model [num_sets];
    wb_req_t   expected_q [$];
    wb_req_t   next_req;
    wb_req_t   held_req;
    logic      held_valid;
    logic      in_flush;
    logic      done_seen;
    logic      end_done;
    int        mismatches;
    int        failures;
    int        flush_starts;
    int        flush_dones;

    assign mismatch_count = mismatches;
    assign failure_count  = failures;

    function automatic int model_count();
        int n;
        n = 0;
        for (int s = 0; s < num_sets; s++) begin
            n += $countones(model[s]);
        end
        return n;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("MISMATCH at time %0t: %s is %0h, expected %0h", $time, name, got, want);
        mismatches++;
    endtask

    task automatic report_failure(string what);
        $display("ERROR at time %0t: %s", $time, what);
        failures++;
    endtask

    initial begin
        mismatches   = 0;
        failures     = 0;
        flush_starts = 0;
        flush_dones  = 0;
        end_done     = 1'b0;
    end

    always @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < num_sets; s++) begin
                model[s] = '0;
            end
            expected_q.delete();
            held_valid = 1'b0;
            in_flush   = 1'b0;
            done_seen  = 1'b0;
        end else begin
            // table is only stable against the model outside a flush
            if (!flush_busy) begin
                if (r_dirty !== model[r_addr][r_way]) begin
                    report_mismatch("r_dirty", r_dirty, model[r_addr][r_way]);
                end
                if (read_check && (r_dirty !== read_expect)) begin
                    report_mismatch("r_dirty (cases file)", r_dirty, read_expect);
                end
                if (dirty_count !== count_width'(model_count())) begin
                    report_mismatch("dirty_count", dirty_count, model_count());
                end
            end
            if (done_seen && flush_busy) begin
                report_failure("flush_busy is still high after flush_done");
            end
            // busy from the cycle after ibar through the done cycle
            if (in_flush && !flush_busy) begin
                report_failure("flush_busy is low while a flush is running");
            end

            // request must hold until acked
            if (held_valid && !wb_valid) begin
                report_failure("wb_valid dropped before wb_ack");
            end else if (held_valid && (wb_req !== held_req)) begin
                report_mismatch("wb_req (held)", wb_req, held_req);
            end
            if (wb_valid && !in_flush) begin
                report_failure("writeback request outside a flush");
            end
            if (wb_valid && wb_ack) begin
                if (expected_q.size() == 0) begin
                    report_failure($sformatf("extra writeback of set %0h way %0d",
                                             wb_req.index, wb_req.way));
                end else begin
                    next_req = expected_q.pop_front();
                    if (wb_req !== next_req) begin
                        report_mismatch("wb_req", wb_req, next_req);
                    end
                end
            end
            held_valid = wb_valid && !wb_ack;
            held_req   = wb_req;

            if (flush_done) begin
                if (!in_flush) begin
                    report_failure("flush_done without a running flush");
                end else begin
                    if (expected_q.size() != 0) begin
                        report_failure($sformatf("flush_done with %0d writebacks missing",
                                                 expected_q.size()));
                    end
                    if (wb_valid) begin
                        report_failure("flush_done while a writeback is pending");
                    end
                    flush_dones++;
                end
                in_flush  = 1'b0;
                done_seen = 1'b1;
            end else begin
                done_seen = 1'b0;
            end

            for (int w = 0; w < num_ways; w++) begin
                if (we[w]) begin
                    model[w_addr][w] = w_data;
                end
            end

            // snapshot the dirty ways in writeback order, then the table is clean
            if (ibar && !flush_busy) begin
                for (int s = 0; s < num_sets; s++) begin
                    for (int w = 0; w < num_ways; w++) begin
                        if (model[s][w]) begin
                            next_req.index = set_index_t'(s);
                            next_req.way   = way_t'(w);
                            expected_q.push_back(next_req);
                        end
                    end
                    model[s] = '0;
                end
                in_flush = 1'b1;
                flush_starts++;
            end

            if (end_check && !end_done) begin
                if (flush_dones != flush_starts) begin
                    report_failure($sformatf("%0d flushes started but %0d completed",
                                             flush_starts, flush_dones));
                end
                if (in_flush) begin
                    report_failure("run ended inside a flush");
                end
                end_done = 1'b1;
            end
        end
    end

endmodule

/* sim/tb_clock.sv */
module tb_clock #(
    parameter int period_ns = 4
)
(
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

endmodule

/* logic/dcache_flush_top.sv */
module dcache_flush_top
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  way_mask_t              we,
    input  set_index_t             w_addr,
    input  logic                   w_data,
    input  set_index_t             r_addr,
    input  logic                   r_way,
    output logic                   r_dirty,
    input  logic                   ibar,
    output logic                   flush_busy,
    output logic                   flush_done,
    output logic                   wb_valid,
    output wb_req_t                wb_req,
    input  logic                   wb_ack,
    output logic [count_width-1:0] dirty_count
);
    set_index_t scan_addr;
    way_mask_t  scan_mask;
    logic       clr_push;
    wb_entry_t  entry;
    wb_entry_t  head;
    logic       q_full;
    logic       q_empty;
    logic       pop;
    logic       drain_idle;

    dirty_table u_table (
        .clk(clk), .rstn(rstn),
        .we(we), .w_addr(w_addr), .w_data(w_data),
        .r_addr(r_addr), .r_way(r_way), .r_dirty(r_dirty),
        .scan_addr(scan_addr), .scan_mask(scan_mask), .clr(clr_push),
        .dirty_count(dirty_count)
    );

    flush_walker u_walker (
        .clk(clk), .rstn(rstn), .ibar(ibar), .dirty_count(dirty_count),
        .scan_addr(scan_addr), .scan_mask(scan_mask),
        .clr_push(clr_push), .entry(entry),
        .full(q_full), .q_empty(q_empty), .drain_idle(drain_idle),
        .flush_busy(flush_busy), .flush_done(flush_done)
    );

    wb_queue #(.payload_t(wb_entry_t)) u_queue (
        .clk(clk), .rstn(rstn),
        .push(clr_push), .push_data(entry),
        .pop(pop), .pop_data(head),
        .full(q_full), .empty(q_empty)
    );

    wb_drain u_drain (
        .clk(clk), .rstn(rstn),
        .empty(q_empty), .head(head), .pop(pop), .idle(drain_idle),
        .wb_valid(wb_valid), .wb_req(wb_req), .wb_ack(wb_ack)
    );

endmodule

/* logic/wb_drain.sv */
module wb_drain
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      empty,
    input  wb_entry_t head,
    output logic      pop,
    output logic      idle,
    output logic      wb_valid,
    output wb_req_t   wb_req,
    input  logic      wb_ack
);
    // ways of the current set not yet requested
    way_mask_t mask_left;

    function automatic way_t first_way(way_mask_t m);
        way_t sel;
        sel = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (m[w]) begin
                sel = way_t'(w);
            end
        end
        return sel;
    endfunction

    function automatic way_mask_t drop_way(way_mask_t m, way_t w);
        way_mask_t r;
        r    = m;
        r[w] = 1'b0;
        return r;
    endfunction

    assign idle = !wb_valid;
    assign pop  = idle && !empty;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_valid  <= 1'b0;
            mask_left <= '0;
        end else if (pop) begin
            wb_valid  <= 1'b1;
            mask_left <= drop_way(head.mask, first_way(head.mask));
        end else if (wb_valid && wb_ack) begin
            // next way goes out right after the ack
            wb_valid  <= |mask_left;
            mask_left <= drop_way(mask_left, first_way(mask_left));
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            wb_req.index <= head.index;
            wb_req.way   <= first_way(head.mask);
        end else if (wb_valid && wb_ack && (|mask_left)) begin
            wb_req.way   <= first_way(mask_left);
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (wb_valid && !wb_ack) |=> (wb_valid && $stable(wb_req)))
        else $error("wb_drain: request changed before ack");

endmodule

/* logic/wb_queue.sv */
module wb_queue
    import dcache_pkg::*;
#(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);
    typedef logic [$clog2(wbq_depth)-1:0] ptr_t;

    payload_t                       mem [wbq_depth];
    ptr_t                           wr_ptr;
    ptr_t                           rd_ptr;
    logic [$clog2(wbq_depth+1)-1:0] count;

    function automatic ptr_t next_ptr(ptr_t p);
        return (p == ptr_t'(wbq_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full     = (count == wbq_depth);
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // occupancy holds when both strobes coincide
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) !(push && full))
        else $error("wb_queue: push while full");
    assert property (@(posedge clk) disable iff (!rstn) !(pop && empty))
        else $error("wb_queue: pop while empty");

endmodule

/* logic/flush_walker.sv */
module flush_walker
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   ibar,
    input  logic [count_width-1:0] dirty_count,
    output set_index_t             scan_addr,
    input  way_mask_t              scan_mask,
    output logic                   clr_push,
    output wb_entry_t              entry,
    input  logic                   full,
    input  logic                   q_empty,
    input  logic                   drain_idle,
    output logic                   flush_busy,
    output logic                   flush_done
);
    typedef enum logic [1:0] {st_idle, st_scan, st_wait, st_done} state_t;

    state_t                 state;
    state_t                 state_next;
    set_index_t             addr;
    logic [count_width-1:0] remaining;
    logic                   set_dirty;
    logic                   last_set;
    logic                   stall;

    assign set_dirty = |scan_mask;
    assign last_set  = (addr == set_index_t'(num_sets - 1));
    // a dirty set waits for room in the queue
    assign stall     = set_dirty && full;

    assign clr_push   = (state == st_scan) && (remaining != '0) && set_dirty && !full;
    assign entry      = '{index: addr, mask: scan_mask};
    assign scan_addr  = addr;
    assign flush_busy = (state != st_idle);
    assign flush_done = (state == st_done);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (ibar) begin
                    state_next = st_scan;
                end
            end
            st_scan: begin
                if ((remaining == '0) || (last_set && !stall)) begin
                    state_next = st_wait;
                end
            end
            // let the drain finish every queued writeback
            st_wait: begin
                if (q_empty && drain_idle) begin
                    state_next = st_done;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= st_idle;
            addr      <= '0;
            remaining <= '0;
        end else begin
            state <= state_next;
            if ((state == st_idle) && ibar) begin
                addr      <= '0;
                remaining <= dirty_count;
            end else if (state == st_scan) begin
                if ((remaining != '0) && !stall) begin
                    addr <= addr + 1'b1;
                end
                if (clr_push) begin
                    remaining <= remaining - count_width'($countones(scan_mask));
                end
            end
        end
    end

    // table contents must agree with the count seeded at ibar
    assert property (@(posedge clk) disable iff (!rstn)
        clr_push |-> (remaining >= count_width'($countones(scan_mask))))
        else $error("flush_walker: remaining dirty count underflow");

endmodule

/* logic/dirty_table.sv */
module dirty_table
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  way_mask_t              we,
    input  set_index_t             w_addr,
    input  logic                   w_data,
    input  set_index_t             r_addr,
    input  logic                   r_way,
    output logic                   r_dirty,
    input  set_index_t             scan_addr,
    output way_mask_t              scan_mask,
    input  logic                   clr,
    output logic [count_width-1:0] dirty_count
);
    way_mask_t              bits_q [num_sets];
    logic [count_width-1:0] count_next;

    assign r_dirty   = bits_q[r_addr][r_way];
    assign scan_mask = bits_q[scan_addr];

    // only bits that actually flip move the count
    always_comb begin
        count_next = dirty_count;
        for (int w = 0; w < num_ways; w++) begin
            if (we[w] && (bits_q[w_addr][w] != w_data)) begin
                if (w_data) begin
                    count_next = count_next + 1'b1;
                end else begin
                    count_next = count_next - 1'b1;
                end
            end
        end
        if (clr) begin
            count_next = count_next - count_width'($countones(scan_mask));
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < num_sets; s++) begin
                bits_q[s] <= '0;
            end
            dirty_count <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (we[w]) begin
                    bits_q[w_addr][w] <= w_data;
                end
            end
            // flush clear of the whole set under scan
            if (clr) begin
                bits_q[scan_addr] <= '0;
            end
            dirty_count <= count_next;
        end
    end

    // pipeline is held off while a flush runs
    assert property (@(posedge clk) disable iff (!rstn) !((|we) && clr))
        else $error("dirty_table: pipeline write during flush clear");

endmodule

/* logic/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    localparam int num_ways    = 2;
    localparam int index_width = 6;
    localparam int num_sets    = 1 << index_width;

    // wide enough for every way of every set being dirty
    localparam int count_width = index_width + 2;

    // writeback queue depth
    localparam int wbq_depth   = 4;

    typedef logic [index_width-1:0]       set_index_t;
    typedef logic [num_ways-1:0]          way_mask_t;
    typedef logic [$clog2(num_ways)-1:0]  way_t;

    // one dirty set, as pushed by the walker
    typedef struct packed {
        set_index_t index;
        way_mask_t  mask;
    } wb_entry_t;

    // one writeback toward memory
    typedef struct packed {
        set_index_t index;
        way_t       way;
    } wb_req_t;

endpackage
